// File: hw/ringMapPkg.sv
/* Ring node and address map */

package ringMapPkg;

	// requester identity, bits 7..2 are its group
	localparam logic [7:0] reqNodeId = 8'h14;

	// group the bridge picks out of seq[15:10]
	localparam logic [5:0] bridgeGroup = reqNodeId[7:2];

	// tag restored above an L2 address on the way back
	localparam logic [15:0] addrHiPhys = 16'h00F0;

	localparam int l1AddrBits = 48; // L1 ring address width
	localparam int l2AddrBits = 32; // L2 ring address width

	// memory node storage, 16-byte words
	localparam int memWords     = 64;
	localparam int memIndexBits = 6;
	localparam int memIndexLsb  = 4; // word index is addr[9:4]

endpackage

// File: hw/ringMsgPkg.sv
/* Ring message format */

package ringMsgPkg;

	// low byte of the operation mode, top two bits give the class
	typedef enum logic [7:0]
	{
		opmIdle      = 8'h00,
		opmLoadReq   = 8'h80,
		opmStoreReq  = 8'h81,
		opmLoadResp  = 8'h40,
		opmStoreResp = 8'h41
	} ringOpm_e;

	localparam logic [1:0] opmClassReq  = 2'b10; // opm[7:6] of a request
	localparam logic [1:0] opmClassResp = 2'b01; // opm[7:6] of a response

	// one slot on the L1 ring, 208 bits
	typedef struct packed
	{
		logic [15:0]                     seq;     // group and counter
		logic [7:0]                      opmRsvd; // always zero
		ringOpm_e                        opm;
		logic [ringMapPkg::l1AddrBits-1:0] addr;
		logic [127:0]                    data;
	} l1Slot_t;

	// one slot on the L2 ring, 192 bits
	typedef struct packed
	{
		logic [15:0]                     seq;
		logic [7:0]                      opmRsvd;
		ringOpm_e                        opm;
		logic [ringMapPkg::l2AddrBits-1:0] addr; // physical low address
		logic [127:0]                    data;
	} l2Slot_t;

	// command presented to the requester
	typedef struct packed
	{
		ringOpm_e                        opm;
		logic [ringMapPkg::l1AddrBits-1:0] addr;
		logic [127:0]                    data;
	} ringCmd_t;

	// returned message, 176 bits
	typedef struct packed
	{
		logic [ringMapPkg::l1AddrBits-1:0] addr;
		logic [127:0]                    data;
	} ringResp_t;

endpackage

// File: hw/ringReqNode.sv
/* L1 requester ring stop */

`timescale 1ns/1ps

module ringReqNode
(
	input  logic                  clock,
	input  logic                  rstN,
	input  logic                  cmdValid,
	input  ringMsgPkg::ringCmd_t  cmd,
	input  ringMsgPkg::l1Slot_t   l1In,
	output ringMsgPkg::l1Slot_t   l1Out,
	output logic                  busy,
	output logic                  respValid,
	output ringMsgPkg::ringResp_t resp
);

	import ringMsgPkg::*;
	import ringMapPkg::*;

	typedef enum logic [1:0]
	{
		stIdle, // no command held
		stPend, // waiting for an idle slot
		stWait  // request on the ring
	} reqState_e;

	reqState_e   state;
	ringCmd_t    cmdReg;
	logic [9:0]  seqCnt;
	logic [15:0] curSeq;
	logic        respHit;
	logic        insertOk;
	l1Slot_t     l1Next;

	assign curSeq = {reqNodeId[7:2], seqCnt};

	assign respHit = (state == stWait) && (l1In.opm[7:6] == opmClassResp) &&
		(l1In.seq == curSeq);
	assign insertOk = (state == stPend) && (l1In.opm == opmIdle);

	always_comb
	begin
		l1Next = l1In; // forward by default
		if (respHit)
		begin
			l1Next     = '0;
			l1Next.opm = opmIdle; // response retired here
		end
		else if (insertOk)
		begin
			l1Next.seq     = curSeq;
			l1Next.opmRsvd = '0;
			l1Next.opm     = cmdReg.opm;
			l1Next.addr    = cmdReg.addr;
			l1Next.data    = cmdReg.data;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			state     <= stIdle;
			seqCnt    <= '0;
			respValid <= 1'b0;
		end
		else
		begin
			respValid <= 1'b0;
			case (state)
				stIdle:
					if (cmdValid)
						state <= stPend; // cmdValid while busy never reaches here
				stPend:
					if (insertOk)
						state <= stWait;
				stWait:
					if (respHit)
					begin
						state     <= stIdle;
						respValid <= 1'b1;
						seqCnt    <= seqCnt + 10'd1;
					end
				default:
					state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == stIdle && cmdValid)
			cmdReg <= cmd;
		if (respHit)
			resp <= '{addr: l1In.addr, data: l1In.data};
	end

	always_ff @(posedge clock)
	begin
		l1Out <= l1Next;
		if (!rstN)
		begin
			l1Out.opmRsvd <= '0;
			l1Out.opm     <= opmIdle;
		end
	end

	assign busy = (state != stIdle);

	// the ring must not produce an answer nobody asked for
	assert property (@(posedge clock) disable iff (!rstN)
		((l1In.opm[7:6] == opmClassResp) && (l1In.seq[15:10] == reqNodeId[7:2])) |-> busy)
		else $error("response arrived while requester idle");

endmodule

// File: hw/ringL1Bridge.sv
/* L1 to L2 ring bridge */

`timescale 1ns/1ps

module ringL1Bridge
(
	input  logic                clock,
	input  logic                rstN,
	input  ringMsgPkg::l1Slot_t l1In,
	output ringMsgPkg::l1Slot_t l1Out,
	input  ringMsgPkg::l2Slot_t l2In,
	output ringMsgPkg::l2Slot_t l2Out
);

	import ringMsgPkg::*;
	import ringMapPkg::*;

	logic    l1IsIdle;
	logic    l2IsIdle;
	logic    l1IsReq;  // request heading for memory
	logic    l2IsResp; // response for our group
	logic    holdL2b;  // blocks the L1 to L2 move
	logic    holdL1b;  // blocks the L2 to L1 move
	logic    takeL1;   // L1 slot gets replaced
	logic    takeL2;   // L2 slot gets replaced
	l1Slot_t l1Req;    // what goes onto L1 in place of the slot
	l2Slot_t l2Req;    // what goes onto L2 in place of the slot
	l1Slot_t l1Next;
	l2Slot_t l2Next;

	assign l1IsIdle = (l1In.opm == opmIdle);
	assign l2IsIdle = (l2In.opm == opmIdle);
	assign l1IsReq  = (l1In.opm[7:6] == opmClassReq);
	assign l2IsResp = (l2In.opm[7:6] == opmClassResp) && (l2In.seq[15:10] == bridgeGroup);

	always_comb
	begin
		holdL1b = 1'b0;
		holdL2b = 1'b0;

		// foreign traffic on the far ring leaves no room
		if (!l1IsIdle && !l1IsReq)
			holdL1b = 1'b1;
		if (!l2IsIdle && !l2IsResp)
			holdL2b = 1'b1;

		l1Req         = '0;
		l1Req.opm     = opmIdle;
		l2Req         = '0;
		l2Req.opm     = opmIdle;

		if (l2IsResp)
		begin
			l1Req.seq  = l2In.seq;
			l1Req.opm  = l2In.opm;
			l1Req.addr = {addrHiPhys, l2In.addr}; // restore the high tag
			l1Req.data = l2In.data;
		end

		if (l1IsReq)
		begin
			l2Req.seq  = l1In.seq;
			l2Req.opm  = l1In.opm;
			l2Req.addr = l1In.addr[l2AddrBits-1:0]; // high bits dropped
			l2Req.data = l1In.data;
		end
	end

	// a swap is possible when both rings hand each other a message
	assign takeL1 = l1IsIdle || (l1IsReq && !holdL2b);
	assign takeL2 = l2IsIdle || (l2IsResp && !holdL1b);

	assign l1Next = takeL1 ? l1Req : l1In; // otherwise circulate and retry
	assign l2Next = takeL2 ? l2Req : l2In;

	always_ff @(posedge clock)
	begin
		l1Out <= l1Next;
		l2Out <= l2Next;
		if (!rstN)
		begin
			l1Out.opmRsvd <= '0;
			l1Out.opm     <= opmIdle;
			l2Out.opmRsvd <= '0;
			l2Out.opm     <= opmIdle;
		end
	end

	// only known opcodes leave the bridge
	assert property (@(posedge clock) disable iff (!rstN)
		(l1Out.opm inside {opmIdle, opmLoadReq, opmStoreReq, opmLoadResp, opmStoreResp}) &&
		(l2Out.opm inside {opmIdle, opmLoadReq, opmStoreReq, opmLoadResp, opmStoreResp}))
		else $error("bridge output carries an unknown opcode");

	// responses handed to L1 carry the physical tag
	assert property (@(posedge clock) disable iff (!rstN)
		(l1Out.opm[7:6] == opmClassResp) |-> (l1Out.addr[47:32] == addrHiPhys))
		else $error("L1 response without addrHiPhys tag");

endmodule

// File: hw/ringMemNode.sv
/* L2 memory ring stop */

`timescale 1ns/1ps

module ringMemNode
(
	input  logic                clock,
	input  logic                rstN,
	input  ringMsgPkg::l2Slot_t l2In,
	output ringMsgPkg::l2Slot_t l2Out
);

	import ringMsgPkg::*;
	import ringMapPkg::*;

	logic [127:0]            mem [memWords]; // 16-byte words
	logic [memIndexBits-1:0] memIdx;
	logic                    isReq;
	logic                    isStore;
	l2Slot_t                 l2Next;

	initial
	begin
		for (int i = 0; i < memWords; i++)
			mem[i] = '0;
	end

	assign memIdx  = l2In.addr[memIndexLsb +: memIndexBits];
	assign isReq   = (l2In.opm[7:6] == opmClassReq);
	assign isStore = (l2In.opm == opmStoreReq);

	// answer keeps seq and address
	always_comb
	begin
		l2Next = l2In;
		if (isReq)
		begin
			if (isStore)
			begin
				l2Next.opm  = opmStoreResp;
				l2Next.data = l2In.data; // echo the written word
			end
			else
			begin
				l2Next.opm  = opmLoadResp;
				l2Next.data = mem[memIdx];
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (rstN && isStore)
			mem[memIdx] <= l2In.data;
	end

	always_ff @(posedge clock)
	begin
		l2Out <= l2Next;
		if (!rstN)
		begin
			l2Out.opmRsvd <= '0;
			l2Out.opm     <= opmIdle;
		end
	end

	/*
	 * the word index of a request must be known and fall inside the
	 * array, else the reply would carry garbage one cycle later
	 */
	assert property (@(posedge clock) disable iff (!rstN)
		isReq |-> (!$isunknown(memIdx) && (int'(memIdx) < memWords)))
		else $error("memory index out of range");

endmodule

// File: hw/ringSubsystem.sv
/* Two-level memory ring top */

`timescale 1ns/1ps

module ringSubsystem
(
	input  logic                  clock,
	input  logic                  rstN,
	input  logic                  cmdValid,
	input  ringMsgPkg::ringCmd_t  cmd,
	output logic                  busy,
	output logic                  respValid,
	output ringMsgPkg::ringResp_t resp
);

	import ringMsgPkg::*;

	l1Slot_t reqToBridge; // L1 ring, requester side
	l1Slot_t bridgeToReq;
	l2Slot_t bridgeToMem; // L2 ring, memory side
	l2Slot_t memToBridge;

	ringReqNode reqNode0
	(
		.clock     (clock),
		.rstN      (rstN),
		.cmdValid  (cmdValid),
		.cmd       (cmd),
		.l1In      (bridgeToReq),
		.l1Out     (reqToBridge),
		.busy      (busy),
		.respValid (respValid),
		.resp      (resp)
	);

	ringL1Bridge bridge0
	(
		.clock (clock),
		.rstN  (rstN),
		.l1In  (reqToBridge),
		.l1Out (bridgeToReq),
		.l2In  (memToBridge),
		.l2Out (bridgeToMem)
	);

	ringMemNode memNode0
	(
		.clock (clock),
		.rstN  (rstN),
		.l2In  (bridgeToMem),
		.l2Out (memToBridge)
	);

endmodule

// File: tb/ringSubsystemTb.sv
/* Ring subsystem testbench */

`timescale 1ns/1ps

module ringSubsystemTb;

	import ringMsgPkg::*;
	import ringMapPkg::*;

	localparam int clockPeriod  = 8;
	localparam int resetCycles  = 8;
	localparam int randSeed     = 70506;
	localparam int numEntries   = 6 + 2 * memWords; // directed part then a full sweep
	localparam int cyclesPerRun = 64;
	localparam int watchdogCycles = resetCycles + numEntries * cyclesPerRun;

	typedef struct packed
	{
		ringOpm_e                 opm;
		logic [l1AddrBits-1:0]    addr;
		logic [127:0]             data;
		logic [127:0]             expData; // from the model memory
		logic                     pulseBusy; // extra cmdValid while busy
	} tblEntry_t;

	logic      clock;
	logic      rstN;
	logic      cmdValid;
	ringCmd_t  cmd;
	logic      busy;
	logic      respValid;
	ringResp_t resp;

	tblEntry_t    stimTbl [numEntries];
	logic [127:0] modelMem [memWords];
	int           entryCnt;
	int           errorCount;
	int           respCount;

	ringSubsystem dut0
	(
		.clock     (clock),
		.rstN      (rstN),
		.cmdValid  (cmdValid),
		.cmd       (cmd),
		.busy      (busy),
		.respValid (respValid),
		.resp      (resp)
	);

	initial
	begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	// old value at the edge so each pulse counts once
	always @(posedge clock)
	begin
		if (rstN && respValid)
			respCount <= respCount + 1;
	end

	initial
	begin
		#(watchdogCycles * clockPeriod);
		$display("timeout: the run did not finish within %0d cycles", watchdogCycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic logic [127:0] randWord();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	task automatic addEntry(input ringOpm_e opm, input logic [l1AddrBits-1:0] addr,
		input logic [127:0] data, input logic pulseBusy);
		int idx;
		idx = int'(addr[memIndexLsb +: memIndexBits]); // only bits 9..4 select the word
		stimTbl[entryCnt].opm       = opm;
		stimTbl[entryCnt].addr      = addr;
		stimTbl[entryCnt].data      = data;
		stimTbl[entryCnt].pulseBusy = pulseBusy;
		if (opm == opmStoreReq)
		begin
			modelMem[idx] = data;
			stimTbl[entryCnt].expData = data; // store echoes the word
		end
		else
			stimTbl[entryCnt].expData = modelMem[idx];
		entryCnt++;
	endtask

	task automatic buildTable();
		for (int i = 0; i < memWords; i++)
			modelMem[i] = '0;
		entryCnt = 0;
		addEntry(opmStoreReq, 48'h0000_0000_0030, randWord(), 1'b0);
		addEntry(opmLoadReq,  48'h0000_0000_0030, '0, 1'b0);
		addEntry(opmLoadReq,  48'h0000_0000_0200, '0, 1'b0); // never written
		addEntry(opmStoreReq, 48'hABCD_0000_0120, randWord(), 1'b0); // high bits set
		addEntry(opmLoadReq,  48'h0000_0000_0120, '0, 1'b1);
		addEntry(opmLoadReq,  48'h5555_FFFF_0120, '0, 1'b0); // aliases index 0x12
		for (int i = 0; i < memWords; i++)
			addEntry(opmStoreReq, 48'(i) << memIndexLsb, randWord(), 1'b0);
		for (int i = 0; i < memWords; i++)
			addEntry(opmLoadReq, 48'(i) << memIndexLsb, '0, 1'b0);
	endtask

	task automatic checkData(input ringResp_t got, input ringResp_t exp, input int idx);
		if (got.data !== exp.data)
		begin
			$display("mismatch resp.data test %0d: got %h expected %h", idx, got.data, exp.data);
			errorCount++;
		end
	endtask

	task automatic checkAddr(input logic [l1AddrBits-1:0] got,
		input logic [l1AddrBits-1:0] exp, input int idx);
		if (got !== exp)
		begin
			$display("mismatch resp.addr test %0d: got %h expected %h", idx, got, exp);
			errorCount++;
		end
	endtask

	task automatic runEntry(input tblEntry_t ent, input int idx);
		ringResp_t expResp;
		int        errBefore;
		errBefore = errorCount;
		@(negedge clock);
		cmd      = '{opm: ent.opm, addr: ent.addr, data: ent.data};
		cmdValid = 1'b1;
		@(negedge clock);
		cmdValid = 1'b0;
		if (busy !== 1'b1)
		begin
			$display("test %0d: busy did not rise after an accepted command", idx);
			errorCount++;
		end
		if (ent.pulseBusy)
		begin
			@(negedge clock);
			if (busy !== 1'b1)
			begin
				$display("test %0d: busy fell before the extra command was pulsed", idx);
				errorCount++;
			end
			cmd      = '{opm: opmStoreReq, addr: ent.addr, data: ~ent.data}; // must be ignored
			cmdValid = 1'b1;
			@(negedge clock);
			cmdValid = 1'b0;
		end
		while (respValid !== 1'b1)
			@(negedge clock);
		expResp.addr = {addrHiPhys, ent.addr[l2AddrBits-1:0]};
		expResp.data = ent.expData;
		checkData(resp, expResp, idx);
		checkAddr(resp.addr, expResp.addr, idx);
		if (busy !== 1'b0)
		begin
			$display("test %0d: busy still high while the response is presented", idx);
			errorCount++;
		end
		@(negedge clock);
		if (respCount != idx + 1)
		begin
			$display("test %0d: %0d responses seen, expected %0d", idx, respCount, idx + 1);
			errorCount++;
		end
		$display("test %0d %s addr %h: %s", idx, ent.opm.name(), ent.addr,
			(errorCount == errBefore) ? "ok" : "fail");
	endtask

	initial
	begin
		rstN       = 1'b0;
		cmdValid   = 1'b0;
		cmd        = '0;
		errorCount = 0;
		respCount  = 0;
		void'($urandom(randSeed));
		buildTable();

		repeat (resetCycles) @(negedge clock);
		rstN = 1'b1;

		// quiet ring before the first command
		repeat (4) @(negedge clock);
		if (busy !== 1'b0 || respValid !== 1'b0 || respCount != 0)
		begin
			$display("after reset: busy or respValid not low, or a response without a command");
			errorCount++;
		end

		for (int i = 0; i < numEntries; i++)
			runEntry(stimTbl[i], i);

		repeat (16) @(negedge clock);
		if (respCount != numEntries)
		begin
			$display("extra responses: %0d seen for %0d commands", respCount, numEntries);
			errorCount++;
		end

		$display("done: %0d tests, %0d responses, %0d errors", numEntries, respCount, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: filelist.f
hw/ringMapPkg.sv
hw/ringMsgPkg.sv
hw/ringReqNode.sv
hw/ringL1Bridge.sv
hw/ringMemNode.sv
hw/ringSubsystem.sv
tb/ringSubsystemTb.sv

// File: Bender.yml
package:
  name: ring_subsystem

sources:
  - hw/ringMapPkg.sv
  - hw/ringMsgPkg.sv
  - hw/ringReqNode.sv
  - hw/ringL1Bridge.sv
  - hw/ringMemNode.sv
  - hw/ringSubsystem.sv
  - target: test
    files:
      - tb/ringSubsystemTb.sv
